/* sched_params.svh */
// ========================================
// warp scheduler configuration macros
// warp, thread and barrier counts, pc
// width, startup pc and counter widths
// ========================================
`ifndef SCHED_PARAMS_SVH
`define SCHED_PARAMS_SVH

`define SCHED_NUM_WARPS     4
`define SCHED_NUM_THREADS   4
`define SCHED_PC_BITS       32
`define SCHED_NUM_BARRIERS  2

// pc bump per issued instruction
`define SCHED_PC_STEP       4
`define SCHED_STARTUP_PC    32'h80000000

`define SCHED_ISSUE_WIDTH   2
`define SCHED_PENDING_BITS  11

`endif

/* sched_pkg.sv */
// ========================================
// scheduler types
// warp, mask and pc words, warp-control
// payload union, control, branch and
// fetch entry structs
// ========================================
`include "sched_params.svh"

package sched_pkg;

    typedef logic [$clog2(`SCHED_NUM_WARPS)-1:0]    wid_t;
    typedef logic [`SCHED_NUM_THREADS-1:0]          tmask_t;
    typedef logic [`SCHED_PC_BITS-1:0]              pc_t;
    typedef logic [`SCHED_NUM_WARPS-1:0]            wmask_t;
    typedef logic [$clog2(`SCHED_NUM_BARRIERS)-1:0] bar_id_t;

    typedef enum logic [1:0] {
        CTL_NONE,
        CTL_TMC,
        CTL_WSPAWN,
        CTL_BARRIER
    } ctl_kind_t;

    // widest view sets the payload width
    localparam int CTL_PAYLOAD_BITS = $bits(wmask_t) + $bits(pc_t);

    typedef struct packed {
        logic [CTL_PAYLOAD_BITS-$bits(tmask_t)-1:0] pad;
        tmask_t                                     tmask;
    } tmc_view_t;

    typedef struct packed {
        wmask_t wmask;
        pc_t    pc;
    } wspawn_view_t;

    typedef struct packed {
        logic [CTL_PAYLOAD_BITS-$bits(bar_id_t)-$bits(wid_t)-1:0] pad;
        bar_id_t                                                  id;
        wid_t                                                     size_m1;
    } barrier_view_t;

    typedef union packed {
        tmc_view_t     tmc;
        wspawn_view_t  wspawn;
        barrier_view_t barrier;
    } ctl_payload_u;

    typedef struct packed {
        logic         valid;
        ctl_kind_t    kind;
        wid_t         wid;
        ctl_payload_u payload;
    } warp_ctl_t;

    typedef struct packed {
        logic valid;
        wid_t wid;
        logic taken;
        pc_t  dest;
    } branch_t;

    // record handed to fetch
    typedef struct packed {
        wid_t   wid;
        tmask_t tmask;
        pc_t    pc;
    } sched_entry_t;

endpackage

/* warp_table.sv */
// ========================================
// warp state table
// active, stall, tmask and pc per warp,
// event next-state logic, wspawn holder
// ========================================
`timescale 1ns/1ps
`include "sched_params.svh"

module warp_table import sched_pkg::*; (
    input  logic                              clk,
    input  logic                              reset,
    input  warp_ctl_t                         ctl,
    input  branch_t                           branch,
    input  logic                              unlock_valid,
    input  wid_t                              unlock_wid,
    input  logic                              release_valid,
    input  wmask_t                            release_mask,
    input  logic                              pick_fire,
    input  wid_t                              pick_wid,
    input  logic                              out_fire,
    input  sched_entry_t                      out_entry,
    output wmask_t                            ready_mask,
    output wmask_t                            active_mask,
    output tmask_t [`SCHED_NUM_WARPS-1:0]     tmasks,
    output pc_t    [`SCHED_NUM_WARPS-1:0]     pcs
);

    wmask_t                        active_r, active_n;
    wmask_t                        stalled_r, stalled_n;
    tmask_t [`SCHED_NUM_WARPS-1:0] tmasks_r, tmasks_n;
    pc_t    [`SCHED_NUM_WARPS-1:0] pcs_r, pcs_n;

    // pending wspawn
    logic   spawn_valid;
    wmask_t spawn_wmask;
    pc_t    spawn_pc;
    wid_t   spawn_wid;

    logic single_warp;
    logic spawn_go;
    logic is_tmc;
    logic is_wspawn;

    // exactly one bit set in the active mask
    assign single_warp = (active_r != '0) && ((active_r & (active_r - 1'b1)) == '0);
    assign spawn_go    = spawn_valid && single_warp;
    assign is_tmc      = ctl.valid && (ctl.kind == CTL_TMC);
    assign is_wspawn   = ctl.valid && (ctl.kind == CTL_WSPAWN);

    always_comb begin
        active_n  = active_r;
        stalled_n = stalled_r;
        tmasks_n  = tmasks_r;
        pcs_n     = pcs_r;

        if (unlock_valid) begin
            stalled_n[unlock_wid] = 1'b0;
        end

        if (spawn_go) begin
            active_n = active_n | spawn_wmask;
            for (int i = 0; i < `SCHED_NUM_WARPS; i++) begin
                if (spawn_wmask[i]) begin
                    tmasks_n[i] = tmask_t'(1);
                    pcs_n[i]    = spawn_pc;
                end
            end
            stalled_n[spawn_wid] = 1'b0;
        end

        // zero mask retires the warp
        if (is_tmc) begin
            tmasks_n[ctl.wid]  = ctl.payload.tmc.tmask;
            active_n[ctl.wid]  = (ctl.payload.tmc.tmask != '0);
            stalled_n[ctl.wid] = 1'b0;
        end

        // arrivals short of the count stay stalled
        if (release_valid) begin
            stalled_n = stalled_n & ~release_mask;
        end

        if (branch.valid) begin
            if (branch.taken) begin
                pcs_n[branch.wid] = branch.dest;
            end
            stalled_n[branch.wid] = 1'b0;
        end

        // hold the warp until decode reports back
        if (pick_fire) begin
            stalled_n[pick_wid] = 1'b1;
        end

        if (out_fire) begin
            pcs_n[out_entry.wid] = out_entry.pc + pc_t'(`SCHED_PC_STEP);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active_r    <= wmask_t'(1);
            stalled_r   <= '0;
            tmasks_r    <= '0;
            pcs_r       <= '0;
            tmasks_r[0] <= tmask_t'(1);
            pcs_r[0]    <= pc_t'(`SCHED_STARTUP_PC);
            spawn_valid <= 1'b0;
        end else begin
            active_r  <= active_n;
            stalled_r <= stalled_n;
            tmasks_r  <= tmasks_n;
            pcs_r     <= pcs_n;
            if (spawn_go) begin
                spawn_valid <= 1'b0;
            end
            if (is_wspawn) begin
                spawn_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (is_wspawn) begin
            spawn_wmask <= ctl.payload.wspawn.wmask;
            spawn_pc    <= ctl.payload.wspawn.pc;
            spawn_wid   <= ctl.wid;
        end
    end

    assign ready_mask  = active_r & ~stalled_r;
    assign active_mask = active_r;
    assign tmasks      = tmasks_r;
    assign pcs         = pcs_r;

endmodule

/* barrier_unit.sv */
// ========================================
// local barriers
// arrival counters, waiting masks and
// the release decision
// ========================================
`timescale 1ns/1ps
`include "sched_params.svh"

module barrier_unit import sched_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  warp_ctl_t ctl,
    output logic      release_valid,
    output wmask_t    release_mask
);

    wid_t   [`SCHED_NUM_BARRIERS-1:0] bar_ctrs;
    wmask_t [`SCHED_NUM_BARRIERS-1:0] bar_masks;

    logic    is_bar;
    logic    bar_full;
    bar_id_t bar_id;
    wmask_t  arrive_mask;

    assign is_bar      = ctl.valid && (ctl.kind == CTL_BARRIER);
    assign bar_id      = ctl.payload.barrier.id;
    // last arrival completes the group
    assign bar_full    = (bar_ctrs[bar_id] == ctl.payload.barrier.size_m1);
    assign arrive_mask = bar_masks[bar_id] | (wmask_t'(1) << ctl.wid);

    assign release_valid = is_bar && bar_full;
    assign release_mask  = arrive_mask;

    always_ff @(posedge clk) begin
        if (reset) begin
            bar_ctrs  <= '0;
            bar_masks <= '0;
        end else if (is_bar) begin
            if (bar_full) begin
                bar_ctrs[bar_id]  <= '0;
                bar_masks[bar_id] <= '0;
            end else begin
                bar_ctrs[bar_id]  <= bar_ctrs[bar_id] + 1'b1;
                bar_masks[bar_id] <= arrive_mask;
            end
        end
    end

endmodule

/* warp_select.sv */
// ========================================
// ready warp pick
// lowest-index priority encoder and
// tmask/pc mux
// ========================================
`timescale 1ns/1ps
`include "sched_params.svh"

module warp_select import sched_pkg::*; (
    input  wmask_t                        ready_mask,
    input  tmask_t [`SCHED_NUM_WARPS-1:0] tmasks,
    input  pc_t    [`SCHED_NUM_WARPS-1:0] pcs,
    output logic                          pick_valid,
    output sched_entry_t                  pick
);

    wid_t sel;

    // scan downward so the lowest ready index wins
    always_comb begin
        sel = '0;
        for (int i = `SCHED_NUM_WARPS - 1; i >= 0; i--) begin
            if (ready_mask[i]) begin
                sel = wid_t'(i);
            end
        end
    end

    assign pick_valid = (ready_mask != '0);
    assign pick.wid   = sel;
    assign pick.tmask = tmasks[sel];
    assign pick.pc    = pcs[sel];

endmodule

/* sched_out_buf.sv */
// ========================================
// fetch output buffer
// two-entry skid buffer, registered
// output stage
// ========================================
`timescale 1ns/1ps

module sched_out_buf import sched_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         in_valid,
    output logic         in_ready,
    input  sched_entry_t in_data,
    output logic         out_valid,
    input  logic         out_ready,
    output sched_entry_t out_data
);

    logic         out_valid_r;
    sched_entry_t out_data_r;
    logic         skid_valid;
    sched_entry_t skid_data;
    logic         out_free;

    // output slot is empty or drains this cycle
    assign out_free = out_ready || !out_valid_r;
    assign in_ready = !skid_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid_r <= 1'b0;
            skid_valid  <= 1'b0;
        end else if (out_free) begin
            out_valid_r <= skid_valid || in_valid;
            skid_valid  <= 1'b0;
        end else if (in_valid && in_ready) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            out_data_r <= skid_valid ? skid_data : in_data;
        end else if (in_valid && in_ready) begin
            skid_data <= in_data;
        end
    end

    assign out_valid = out_valid_r;
    assign out_data  = out_data_r;

endmodule

/* pending_tracker.sv */
// ========================================
// pending instruction tracking
// in-flight counter and registered busy
// ========================================
`timescale 1ns/1ps
`include "sched_params.svh"

module pending_tracker import sched_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [`SCHED_ISSUE_WIDTH-1:0] issued_cnt,
    input  logic [`SCHED_ISSUE_WIDTH-1:0] committed_cnt,
    input  wmask_t                        active_mask,
    output logic                          busy
);

    logic [`SCHED_PENDING_BITS-1:0] pending;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
            busy    <= 1'b0;
        end else begin
            pending <= pending + `SCHED_PENDING_BITS'(issued_cnt)
                               - `SCHED_PENDING_BITS'(committed_cnt);
            // one cycle behind the live state
            busy    <= (active_mask != '0) || (pending != '0);
        end
    end

endmodule

/* warp_scheduler.sv */
// ========================================
// warp scheduler top
// warp table, barriers, pick, output
// buffer and pending tracker
// ========================================
`timescale 1ns/1ps
`include "sched_params.svh"

module warp_scheduler import sched_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  warp_ctl_t                     ctl,
    input  branch_t                       branch,
    input  logic                          unlock_valid,
    input  wid_t                          unlock_wid,
    input  logic [`SCHED_ISSUE_WIDTH-1:0] issued_cnt,
    input  logic [`SCHED_ISSUE_WIDTH-1:0] committed_cnt,
    output logic                          sched_valid,
    input  logic                          sched_ready,
    output sched_entry_t                  sched_data,
    output logic                          busy
);

    wmask_t                        ready_mask;
    wmask_t                        active_mask;
    tmask_t [`SCHED_NUM_WARPS-1:0] tmasks;
    pc_t    [`SCHED_NUM_WARPS-1:0] pcs;
    logic                          pick_valid;
    logic                          pick_ready;
    sched_entry_t                  pick;
    logic                          release_valid;
    wmask_t                        release_mask;

    logic pick_fire;
    logic out_fire;

    assign pick_fire = pick_valid && pick_ready;
    assign out_fire  = sched_valid && sched_ready;

    warp_table u_warp_table (
        .clk           (clk),
        .reset         (reset),
        .ctl           (ctl),
        .branch        (branch),
        .unlock_valid  (unlock_valid),
        .unlock_wid    (unlock_wid),
        .release_valid (release_valid),
        .release_mask  (release_mask),
        .pick_fire     (pick_fire),
        .pick_wid      (pick.wid),
        .out_fire      (out_fire),
        .out_entry     (sched_data),
        .ready_mask    (ready_mask),
        .active_mask   (active_mask),
        .tmasks        (tmasks),
        .pcs           (pcs)
    );

    barrier_unit u_barrier_unit (
        .clk           (clk),
        .reset         (reset),
        .ctl           (ctl),
        .release_valid (release_valid),
        .release_mask  (release_mask)
    );

    warp_select u_warp_select (
        .ready_mask (ready_mask),
        .tmasks     (tmasks),
        .pcs        (pcs),
        .pick_valid (pick_valid),
        .pick       (pick)
    );

    sched_out_buf u_out_buf (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (pick_valid),
        .in_ready  (pick_ready),
        .in_data   (pick),
        .out_valid (sched_valid),
        .out_ready (sched_ready),
        .out_data  (sched_data)
    );

    pending_tracker u_pending (
        .clk           (clk),
        .reset         (reset),
        .issued_cnt    (issued_cnt),
        .committed_cnt (committed_cnt),
        .active_mask   (active_mask),
        .busy          (busy)
    );

endmodule

/* tb_clock_gen.sv */
// ========================================
// testbench clock and reset
// 10 ns clock, reset held 10 cycles
// ========================================
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // release 1 ns after the tenth edge
    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

/* tb_warp_scheduler.sv */
// ========================================
// warp scheduler testbench
// file-driven event steps, fetch entry
// and busy checks, cycle-limit watchdog
// ========================================
`timescale 1ns/1ps
`include "sched_params.svh"

module tb_warp_scheduler import sched_pkg::*; ();

    localparam int STIM_WORDS      = 256;
    localparam int CYCLES_PER_STEP = 40;
    localparam int SETTLE_CYCLES   = 3;
    localparam int EVENT_WORDS     = 7;
    localparam int RECORD_WORDS    = 3;

    // event codes used in the data file
    localparam int EV_TMC     = 1;
    localparam int EV_WSPAWN  = 2;
    localparam int EV_BARRIER = 3;
    localparam int EV_BRANCH  = 4;
    localparam int EV_UNLOCK  = 5;
    localparam int EV_COUNTS  = 6;

    logic                          clk;
    logic                          reset;
    warp_ctl_t                     ctl;
    branch_t                       branch;
    logic                          unlock_valid;
    wid_t                          unlock_wid;
    logic [`SCHED_ISSUE_WIDTH-1:0] issued_cnt;
    logic [`SCHED_ISSUE_WIDTH-1:0] committed_cnt;
    logic                          sched_valid;
    logic                          sched_ready;
    sched_entry_t                  sched_data;
    logic                          busy;

    logic [31:0]  stim [0:STIM_WORDS-1];
    sched_entry_t exp_q [$];
    int           seed;
    int           cycle_count;
    int           cycle_limit;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    warp_scheduler dut (
        .clk           (clk),
        .reset         (reset),
        .ctl           (ctl),
        .branch        (branch),
        .unlock_valid  (unlock_valid),
        .unlock_wid    (unlock_wid),
        .issued_cnt    (issued_cnt),
        .committed_cnt (committed_cnt),
        .sched_valid   (sched_valid),
        .sched_ready   (sched_ready),
        .sched_data    (sched_data),
        .busy          (busy)
    );

    task automatic end_with_failure();
        $display("Regression failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string msg);
        $display("MISMATCH time=%0t %s", $time, msg);
        end_with_failure();
    endtask

    task automatic expect_entry(input sched_entry_t got, input sched_entry_t want);
        if (got !== want) begin
            report_mismatch($sformatf(
                "entry wid=%0d tmask=%b pc=%h, expected wid=%0d tmask=%b pc=%h",
                got.wid, got.tmask, got.pc, want.wid, want.tmask, want.pc));
        end
    endtask

    task automatic verify_busy(input logic got, input logic want, input int step);
        if (got !== want) begin
            report_mismatch($sformatf("step %0d busy=%b, expected %b", step, got, want));
        end
    endtask

    // wait for the edge and move 1 ns past it
    task automatic advance_cycle();
        @(posedge clk);
        #1;
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: no finish within %0d cycles", cycle_limit);
            end_with_failure();
        end
    endtask

    task automatic clear_event();
        ctl           = '0;
        branch        = '0;
        unlock_valid  = 1'b0;
        unlock_wid    = '0;
        issued_cnt    = '0;
        committed_cnt = '0;
    endtask

    task automatic drive_event(input int kind, input wid_t wid,
                               input logic [31:0] a, input logic [31:0] b);
        case (kind)
            EV_TMC: begin
                ctl.valid               = 1'b1;
                ctl.kind                = CTL_TMC;
                ctl.wid                 = wid;
                ctl.payload.tmc.tmask   = a[`SCHED_NUM_THREADS-1:0];
            end
            EV_WSPAWN: begin
                ctl.valid                = 1'b1;
                ctl.kind                 = CTL_WSPAWN;
                ctl.wid                  = wid;
                ctl.payload.wspawn.wmask = a[`SCHED_NUM_WARPS-1:0];
                ctl.payload.wspawn.pc    = b;
            end
            EV_BARRIER: begin
                ctl.valid                   = 1'b1;
                ctl.kind                    = CTL_BARRIER;
                ctl.wid                     = wid;
                ctl.payload.barrier.id      = bar_id_t'(a);
                ctl.payload.barrier.size_m1 = wid_t'(b);
            end
            EV_BRANCH: begin
                branch.valid = 1'b1;
                branch.wid   = wid;
                branch.taken = a[0];
                branch.dest  = b;
            end
            EV_UNLOCK: begin
                unlock_valid = 1'b1;
                unlock_wid   = wid;
            end
            EV_COUNTS: begin
                issued_cnt    = a[`SCHED_ISSUE_WIDTH-1:0];
                committed_cnt = b[`SCHED_ISSUE_WIDTH-1:0];
            end
            default: begin
            end
        endcase
    endtask

    task automatic drive_ready(input logic rnd);
        logic [31:0] rand_word;
        if (rnd) begin
            rand_word   = $random(seed);
            sched_ready = rand_word[0];
        end else begin
            sched_ready = 1'b1;
        end
    endtask

    // outputs are stable at the falling edge
    task automatic observe_output();
        sched_entry_t want;
        @(negedge clk);
        if (sched_valid && sched_ready) begin
            if (exp_q.size() == 0) begin
                report_mismatch($sformatf("unexpected entry wid=%0d pc=%h",
                                          sched_data.wid, sched_data.pc));
            end else begin
                want = exp_q.pop_front();
                expect_entry(sched_data, want);
            end
        end
    endtask

    initial begin
        int           num_steps;
        int           ptr;
        int           kind;
        int           count;
        wid_t         wid;
        logic [31:0]  arg_a;
        logic [31:0]  arg_b;
        logic         rnd;
        logic         want_busy;
        sched_entry_t rec;

        clear_event();
        sched_ready = 1'b0;
        seed        = 32'h779c0318;
        cycle_count = 0;
        cycle_limit = CYCLES_PER_STEP;

        $readmemh("sched_input.txt", stim);
        num_steps = int'(stim[0]);
        if ($isunknown(stim[0]) || num_steps == 0) begin
            $display("stimulus file sched_input.txt is missing or lists no steps");
            end_with_failure();
        end
        cycle_limit = CYCLES_PER_STEP * num_steps;
        ptr         = 1;

        @(posedge clk);
        wait (reset === 1'b0);

        for (int s = 0; s < num_steps; s++) begin
            kind      = int'(stim[ptr]);
            wid       = wid_t'(stim[ptr + 1]);
            arg_a     = stim[ptr + 2];
            arg_b     = stim[ptr + 3];
            count     = int'(stim[ptr + 4]);
            rnd       = stim[ptr + 5][0];
            want_busy = stim[ptr + 6][0];
            ptr       = ptr + EVENT_WORDS;
            for (int i = 0; i < count; i++) begin
                rec.wid   = wid_t'(stim[ptr]);
                rec.tmask = tmask_t'(stim[ptr + 1]);
                rec.pc    = pc_t'(stim[ptr + 2]);
                exp_q.push_back(rec);
                ptr = ptr + RECORD_WORDS;
            end

            // event strobe lasts a single cycle
            advance_cycle();
            drive_event(kind, wid, arg_a, arg_b);
            drive_ready(rnd);
            observe_output();
            while (exp_q.size() != 0) begin
                advance_cycle();
                clear_event();
                drive_ready(rnd);
                observe_output();
            end

            // quiet window with no new entry expected
            repeat (SETTLE_CYCLES) begin
                advance_cycle();
                clear_event();
                sched_ready = 1'b1;
                observe_output();
            end
            verify_busy(busy, want_busy, s);
        end

        $display("Regression passed");
        $finish;
    end

endmodule

/* sched_input.txt */
// all hex; first word is the step count, then per step: kind wid a b k rnd busy
// followed by k fetch records: wid tmask pc
// kind 0 none 1 tmc 2 wspawn 3 barrier 4 branch 5 unlock 6 counts (a issued, b committed)
16
0 0 0 0 1 0 1
0 1 80000000
5 0 0 0 1 0 1
0 1 80000004
5 0 0 0 1 0 1
0 1 80000008
1 0 3 0 1 0 1
0 3 8000000c
2 0 e 1000 4 0 1
0 3 80000010
1 1 1000
2 1 1000
3 1 1000
3 0 0 3 0 0 1
3 1 0 3 0 0 1
3 2 0 3 0 0 1
3 3 0 3 4 0 1
0 3 80000014
1 1 1004
2 1 1004
3 1 1004
4 1 1 2000 1 0 1
1 1 2000
4 2 0 3000 1 0 1
2 1 1008
3 0 1 3 0 0 1
3 1 1 3 0 0 1
3 2 1 3 0 0 1
3 3 1 3 4 1 1
0 3 80000018
1 1 2004
2 1 100c
3 1 1008
6 0 2 0 0 0 1
1 0 0 0 0 0 1
1 1 0 0 0 0 1
1 2 0 0 0 0 1
1 3 0 0 0 0 1
6 0 0 1 0 0 1
6 0 0 1 0 0 0

/* filelist.f */
+incdir+.
sched_pkg.sv
warp_table.sv
barrier_unit.sv
warp_select.sv
sched_out_buf.sv
pending_tracker.sv
warp_scheduler.sv
tb_clock_gen.sv
tb_warp_scheduler.sv

/* Makefile */
TOP = tb_warp_scheduler

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): filelist.f *.sv *.svh
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal -f filelist.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Regression passed"

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps -f filelist.f --top-module warp_scheduler

clean:
	rm -rf obj_dir
